//--- spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Command word layout is {wr, addr[2:0], data[7:0]}
`define SPI_CMD_WIDTH 12

// Bits clocked in from miso after a read command
`define SPI_READ_WIDTH 8

// clk cycles per sclk half period (one SPI bit is two of these)
`define SPI_HALF_PERIOD 4

`endif

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

  // One command word, MSB first on the wire
  typedef struct packed {
    logic       wr;    // 1 = write, 0 = read
    logic [2:0] addr;
    logic [7:0] data;  // Ignored by the slave on reads
  } spi_cmd_t;

  // Frame sequencer states
  typedef enum logic [2:0] {
    idle,        // cs high, waiting for a command
    lead,        // cs low, first half period before the first rising sclk
    shift_cmd,   // 12 command bits on mosi
    shift_read,  // 8 bits sampled from miso
    finish       // Divider stopped, cs rises on the next edge
  } spi_state_e;

endpackage

`default_nettype wire

//--- spi_edge_if.sv
`timescale 1ns/1ps
`default_nettype none

// Link between the sclk divider and the frame sequencer
interface spi_edge_if;

  logic run;   // Divider enable, held high for the whole frame
  logic sclk;  // Registered SPI clock, low while run is low
  logic rise;  // High in the clk cycle whose closing edge raises sclk
  logic fall;  // Same for the falling sclk edge

  modport gen (
    input  run,
    output sclk,
    output rise,
    output fall
  );

  modport seq (
    output run,
    input  sclk,
    input  rise,
    input  fall
  );

endinterface

`default_nettype wire

//--- spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_sclk_gen #(
  parameter int HALF_PERIOD = `SPI_HALF_PERIOD
) (
  input  logic    clk,
  input  logic    rst_n,
  spi_edge_if.gen edge_bus
);

  localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_PERIOD - 1);

  logic [CNT_W-1:0] cnt;
  logic             sclk_q;
  logic             toggle;

  // Last cycle of a half period while the frame runs
  assign toggle = edge_bus.run && (cnt == CNT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt    <= '0;
      sclk_q <= 1'b0;
    end
    else if (!edge_bus.run)
    begin
      cnt    <= '0;     // Next frame starts with a full half period
      sclk_q <= 1'b0;
    end
    else if (toggle)
    begin
      cnt    <= '0;
      sclk_q <= ~sclk_q;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  assign edge_bus.sclk = sclk_q;

  // Strobes announce the level sclk takes on the coming clk edge, so the
  // sequencer moves mosi and samples miso on the same edge as sclk
  assign edge_bus.rise = toggle && !sclk_q;
  assign edge_bus.fall = toggle && sclk_q;

endmodule

`default_nettype wire

//--- spi_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_pkg::spi_cmd_t          cmd,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  spi_edge_if.seq                    edge_bus,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);

  localparam int CMD_BITS   = `SPI_CMD_WIDTH;
  localparam int FRAME_BITS = `SPI_CMD_WIDTH + `SPI_READ_WIDTH;
  localparam int CNT_W      = $clog2(FRAME_BITS + 1);

  // Fall strobe counts at which the command part and the whole frame end
  localparam logic [CNT_W-1:0] CMD_LAST   = CNT_W'(CMD_BITS - 1);
  localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(FRAME_BITS - 1);

  spi_pkg::spi_state_e state;
  spi_pkg::spi_state_e state_nxt;

  logic [`SPI_CMD_WIDTH-1:0]  shift_buf;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`SPI_READ_WIDTH-1:0] capture;
  logic                       frame_wr;
  logic                       accept;
  logic                       cmd_done;
  logic                       read_done;

  assign accept    = cmd_vld && cmd_rdy;
  assign cmd_done  = edge_bus.fall && (bit_cnt == CMD_LAST);
  assign read_done = edge_bus.fall && (bit_cnt == FRAME_LAST);

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_pkg::idle:
      begin
        if (accept)
          state_nxt = spi_pkg::lead;
      end
      spi_pkg::lead:
      begin
        if (edge_bus.rise)
          state_nxt = spi_pkg::shift_cmd;  // Slave has bit 11 now
      end
      spi_pkg::shift_cmd:
      begin
        if (cmd_done)
        begin
          if (frame_wr)
            state_nxt = spi_pkg::finish;
          else
            state_nxt = spi_pkg::shift_read;
        end
      end
      spi_pkg::shift_read:
      begin
        if (read_done)
          state_nxt = spi_pkg::finish;
      end
      spi_pkg::finish:
      begin
        state_nxt = spi_pkg::idle;
      end
      default:
      begin
        state_nxt = spi_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= spi_pkg::idle;
    else
      state <= state_nxt;
  end

  // Command side
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_buf <= '0;      // Keeps mosi low until the first command
      frame_wr  <= 1'b0;
    end
    else if (accept)
    begin
      shift_buf <= cmd;
      frame_wr  <= cmd.wr;
    end
    else if (state == spi_pkg::shift_cmd && edge_bus.fall)
    begin
      shift_buf <= {shift_buf[`SPI_CMD_WIDTH-2:0], 1'b0};  // Zeros follow, mosi low
    end
  end

  // One count per falling sclk edge in the frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (accept)
      bit_cnt <= '0;
    else if (edge_bus.fall &&
             (state == spi_pkg::shift_cmd || state == spi_pkg::shift_read))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // miso is sampled on the rising sclk edge, MSB first
  always_ff @(posedge clk)
  begin
    if (state == spi_pkg::shift_read && edge_bus.rise)
      capture <= {capture[`SPI_READ_WIDTH-2:0], miso};
  end

  // Read result goes out as cs rises
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_vld <= 1'b0;
    else
      read_vld <= (state == spi_pkg::finish) && !frame_wr;
  end

  always_ff @(posedge clk)
  begin
    if (state == spi_pkg::finish && !frame_wr)
      read_data <= capture;
  end

  assign cmd_rdy      = (state == spi_pkg::idle);
  assign cs           = (state == spi_pkg::idle);   // Active low
  assign mosi         = shift_buf[`SPI_CMD_WIDTH-1];
  assign edge_bus.run = (state == spi_pkg::lead) ||
                        (state == spi_pkg::shift_cmd) ||
                        (state == spi_pkg::shift_read);

endmodule

`default_nettype wire

//--- spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_master (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0]  cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);

  spi_edge_if edge_bus ();

  // sclk divider
  spi_sclk_gen #(
    .HALF_PERIOD (`SPI_HALF_PERIOD)
  ) sclk_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .edge_bus (edge_bus.gen)
  );

  // Frame control and data path
  spi_sequencer sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (spi_pkg::spi_cmd_t'(cmd_in)),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .edge_bus  (edge_bus.seq),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  assign sclk = edge_bus.sclk;

endmodule

`default_nettype wire

//--- spi_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tb_clk #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset leaves on a falling edge, like every other DUT input
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- spi_master_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                cs,
  input logic                sclk,
  input logic                mosi,
  input logic                fall,
  input logic                cmd_rdy,
  input logic                read_vld,
  input spi_pkg::spi_state_e state
);

  // Mode 0 idles with sclk low
  sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else $error("sclk is high while cs is high");

  vld_single: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
    else $error("read_vld held high for two cycles");

  rdy_during_frame: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
    else $error("cmd_rdy is high during a frame");

  // mosi may only move on a falling sclk edge
  mosi_steady: assert property (@(posedge clk) disable iff (!rst_n)
    (!cs && !fall) |=> $stable(mosi))
    else $error("mosi changed away from a falling sclk edge");

  // Every frame opens with sclk low for the whole first half period
  lead_sclk_low: assert property (@(posedge clk) disable iff (!rst_n)
    (state == spi_pkg::lead) |-> !sclk)
    else $error("sclk high before the first rising edge of a frame");

endmodule

`default_nettype wire

//--- spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_tb;

  localparam int NUM_CMDS    = 200;
  localparam int CLK_NS      = 4;
  localparam int H           = `SPI_HALF_PERIOD;
  localparam int FRAME_BITS  = `SPI_CMD_WIDTH + `SPI_READ_WIDTH;
  localparam int WATCHDOG_NS = NUM_CMDS * (FRAME_BITS * 2 * H + 40) * CLK_NS;

  logic                       clk;
  logic                       rst_n;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_in;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic                       sclk;
  logic                       cs;
  logic                       mosi;
  logic                       miso;
  logic                       read_vld;
  logic [`SPI_READ_WIDTH-1:0] read_data;

  int error_count = 0;
  int frames_done = 0;
  int reads_sent  = 0;
  int vld_pulses  = 0;

  logic [7:0]        shadow_mem [8];  // Follows issued commands only
  logic [7:0]        slave_mem [8];   // Register file behind the pins
  spi_pkg::spi_cmd_t sent_q [$];
  logic [7:0]        expect_q [$];

  spi_pkg::spi_cmd_t slave_shift;
  logic [7:0]        slave_out;
  int                rise_cnt;
  int                fall_cnt;
  int                low_cycles;
  logic              sclk_prev = 1'b0;
  logic              cs_prev = 1'b1;

  spi_tb_clk #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(4)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  spi_master spi_master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  bind spi_master spi_master_assert master_assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs       (cs),
    .sclk     (sclk),
    .mosi     (mosi),
    .fall     (edge_bus.fall),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld),
    .state    (sequencer_i.state)
  );

  task automatic mismatch(input string msg);
    error_count++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic fault(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("Frames %0d of %0d, read pulses %0d of %0d, errors %0d",
             frames_done, NUM_CMDS, vld_pulses, reads_sent, error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  task automatic check_frame();
    spi_pkg::spi_cmd_t exp_cmd;
    logic [7:0]        exp_byte;
    int                exp_rises;
    if (sent_q.size() == 0)
      fault("a frame ended with no command sent");
    else
    begin
      exp_cmd   = sent_q.pop_front();
      exp_byte  = expect_q.pop_front();
      exp_rises = exp_cmd.wr ? `SPI_CMD_WIDTH : FRAME_BITS;
      frames_done++;
      if (slave_shift !== exp_cmd)
        mismatch($sformatf("slave got %03h, sent %03h", slave_shift, exp_cmd));
      if (rise_cnt != exp_rises)
        mismatch($sformatf("%0d rising sclk edges, expected %0d", rise_cnt, exp_rises));
      if (low_cycles != exp_rises * 2 * H + 1)
        mismatch($sformatf("cs low for %0d cycles", low_cycles));
      if (exp_cmd.wr && read_vld !== 1'b0)
        mismatch("read_vld after a write frame");
      if (!exp_cmd.wr && read_vld !== 1'b1)
        mismatch("no read_vld as the read frame ended");
      else if (!exp_cmd.wr && read_data !== exp_byte)
        mismatch($sformatf("read %02h from addr %0d, expected %02h",
                           read_data, exp_cmd.addr, exp_byte));
    end
  endtask

  // Slave model and pin monitor on the falling clk edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (cs_prev && !cs)
      begin
        rise_cnt   = 0;
        fall_cnt   = 0;
        low_cycles = 0;
      end
      if (!cs)
      begin
        low_cycles++;
        if (cmd_rdy !== 1'b0)
          fault("cmd_rdy is high while cs is low");
        if (sclk && !sclk_prev)
        begin
          rise_cnt++;
          if (rise_cnt <= `SPI_CMD_WIDTH)
            slave_shift = {slave_shift[`SPI_CMD_WIDTH-2:0], mosi};
          if (rise_cnt == `SPI_CMD_WIDTH && slave_shift.wr)
            slave_mem[slave_shift.addr] = slave_shift.data;
        end
        if (!sclk && sclk_prev)
        begin
          fall_cnt++;
          if (fall_cnt >= `SPI_CMD_WIDTH && fall_cnt < FRAME_BITS && !slave_shift.wr)
          begin
            if (fall_cnt == `SPI_CMD_WIDTH)
              slave_out = slave_mem[slave_shift.addr];
            miso      = slave_out[7];  // MSB first
            slave_out = slave_out << 1;
          end
          else
            miso = 1'b0;
        end
      end
      if (!cs_prev && cs)
        check_frame();
      if (read_vld === 1'b1)
      begin
        vld_pulses++;
        if (!(!cs_prev && cs))
          fault("read_vld pulsed away from the end of a frame");
      end
    end
    sclk_prev = sclk;
    cs_prev   = cs;
  end

  initial
  begin
    spi_pkg::spi_cmd_t cmd;
    void'($urandom(93));
    cmd_in  = '0;
    cmd_vld = 1'b0;
    miso    = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      shadow_mem[i] = '0;
      slave_mem[i]  = '0;
    end
    @(posedge rst_n);
    if (cs !== 1'b1 || sclk !== 1'b0 || cmd_rdy !== 1'b1 || read_vld !== 1'b0 || mosi !== 1'b0)
      mismatch("pins after reset differ from the idle state");
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      cmd.wr   = 1'($urandom_range(0, 1));
      cmd.addr = 3'($urandom_range(0, 7));
      cmd.data = 8'($urandom_range(0, 255));
      cmd_in   = cmd;
      cmd_vld  = 1'b1;  // Held through the previous frame
      while (cmd_rdy !== 1'b1)
        @(negedge clk);
      @(negedge clk);   // Taken on the rising edge just passed
      sent_q.push_back(cmd);
      if (cmd.wr)
      begin
        shadow_mem[cmd.addr] = cmd.data;
        expect_q.push_back(8'h00);
      end
      else
      begin
        expect_q.push_back(shadow_mem[cmd.addr]);
        reads_sent++;
      end
    end
    cmd_vld = 1'b0;
    cmd_in  = '0;
    while (sent_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (vld_pulses != reads_sent)
      mismatch($sformatf("%0d read_vld pulses for %0d reads", vld_pulses, reads_sent));
    for (int i = 0; i < 8; i++)
    begin
      if (slave_mem[i] !== shadow_mem[i])
        mismatch($sformatf("slave entry %0d holds %02h, expected %02h",
                           i, slave_mem[i], shadow_mem[i]));
    end
    finish_run();
  end

  initial
  begin
    #(WATCHDOG_NS);
    fault("watchdog expired, the run did not finish");
    finish_run();
  end

endmodule

`default_nettype wire

//--- spi_master.f
+incdir+.
spi_pkg.sv
spi_edge_if.sv
spi_sclk_gen.sv
spi_sequencer.sv
spi_master.sv
spi_tb_clk.sv
spi_master_assert.sv
spi_tb.sv

//--- Bender.yml
package:
  name: spi_master

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spi_pkg.sv
      - spi_edge_if.sv
      - spi_sclk_gen.sv
      - spi_sequencer.sv
      - spi_master.sv
  - target: test
    include_dirs:
      - .
    files:
      - spi_tb_clk.sv
      - spi_master_assert.sv
      - spi_tb.sv
